/* sources.f */
+incdir+hdl
hdl/tcu_pkg.sv
hdl/tick_prescaler.sv
hdl/reload_timer.sv
hdl/edge_capture.sv
hdl/event_merger.sv
hdl/tcu_top.sv
testbench/tcu_asserts.sv
testbench/tb_tcu.sv

/* run.sh */
#!/bin/sh
# build and run the tcu testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tcu -f sources.f \
	&& out=$(./obj_dir/Vtb_tcu) \
	&& echo "$out" \
	&& echo "$out" | grep -qx '>>> PASS' \
	|| exit 1

/* testbench/tb_tcu.sv */
// tcu testbench with clock, reset, directed tests, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "tcu_defs.svh"

module tb_tcu;
	import tcu_pkg::*;

	localparam int WD_CYCLES = 60 + 300 + 200 + 700 + 300 + 500;    // test lengths plus margin

	logic clk, rst, i_sig, i_evt_credit, o_tmr_clk, o_evt_valid, o_lost;
	tcu_cfg_t cfg;
	evt_t o_evt;
	evt_t rx_q[$];
	int rx_t[$];
	int cyc, owed, tgl_cnt, err_cnt, test_cnt, err_at_start;
	bit give_credit = 1;
	integer seed = 32'had8d_1086;

	tcu_top tcu_top_inst (.clk(clk), .rst(rst), .i_cfg(cfg), .i_sig(i_sig),
		.i_evt_credit(i_evt_credit), .o_tmr_clk(o_tmr_clk), .o_evt_valid(o_evt_valid),
		.o_evt(o_evt), .o_lost(o_lost));

	bind event_merger tcu_asserts tcu_asserts_inst (.clk(clk), .rst(rst),
		.i_valid(o_evt_valid), .i_evt_credit(i_evt_credit), .i_credit_cnt(credit_cnt),
		.i_wr_en(wr_en), .i_rd_en(rd_en));

	initial begin
		clk = 0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WD_CYCLES * 4);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	// receive records, return credits one per cycle
	always @(posedge clk) begin
		int nxt;
		cyc <= cyc + 1;
		nxt = owed + ((rst && o_evt_valid) ? 1 : 0);
		if (nxt > `TCU_CREDITS) begin
			$display("more records in flight than credits granted");
			err_cnt++;
		end
		if (rst && o_evt_valid) begin
			rx_q.push_back(o_evt);
			rx_t.push_back(cyc);
		end
		i_evt_credit <= give_credit && nxt > 0;
		owed <= (give_credit && nxt > 0) ? nxt - 1 : nxt;
	end

	always @(o_tmr_clk) tgl_cnt++;

	task automatic compare_evt(string name, evt_t got, evt_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_flags(string name, evt_flags_t got, evt_flags_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic wait_records(int n, int limit);
		int t;
		t = 0;
		while (rx_q.size() < n && t < limit) begin
			@(negedge clk);
			t++;
		end
		if (rx_q.size() < n) begin
			$display("timed out waiting for %0d records, got %0d", n, rx_q.size());
			err_cnt++;
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		cfg <= '0;
		repeat (20) @(posedge clk);
		@(negedge clk);
		rx_q.delete();
		rx_t.delete();
	endtask

	task automatic report(string name);
		test_cnt++;
		$display("test %s: %0d errors", name, err_cnt - err_at_start);
		err_at_start = err_cnt;
	endtask

	task automatic test_reset();
		@(negedge clk);
		compare_bit("o_evt_valid", o_evt_valid, 1'b0);
		compare_bit("o_lost", o_lost, 1'b0);
		compare_bit("o_tmr_clk", o_tmr_clk, 1'b0);
		repeat (50) @(negedge clk);
		if (rx_q.size() != 0) begin
			$display("records arrived with nothing enabled");
			err_cnt++;
		end
		report("reset");
	endtask

	task automatic test_timer();
		int div, tv, t0;
		div = $unsigned($random(seed)) % 4;
		tv = 2 + $unsigned($random(seed)) % 4;
		t0 = tgl_cnt;
		@(posedge clk);
		cfg <= '{div: div, tmr_val: tv, tmr_en: 1, cap_en: 1, rise_en: 0, fall_en: 0};
		wait_records(6, 300);
		if (tgl_cnt - t0 != rx_q.size()) begin
			$display("o_tmr_clk changed %0d times for %0d expiries", tgl_cnt - t0, rx_q.size());
			err_cnt++;
		end
		foreach (rx_q[i]) begin
			compare_flags("flags", rx_q[i].flags, '{expire: 1, rise: 0, fall: 0, ovf: 0});
			if (i > 0)
				compare_bit("stamp_step_ok", stamp_t'(rx_q[i].stamp - rx_q[i-1].stamp) == tv + 1, 1'b1);
		end
		go_idle();
		report("timer");
	endtask

	task automatic test_edges();
		int gaps[4] = '{4, 7, 10, 6};
		@(posedge clk);
		cfg <= '{div: 0, tmr_val: 0, tmr_en: 0, cap_en: 1, rise_en: 1, fall_en: 1};
		foreach (gaps[i]) begin
			repeat (gaps[i]) @(posedge clk);
			i_sig <= ~i_sig;
		end
		wait_records(4, 50);
		foreach (rx_q[i]) begin
			compare_flags("flags", rx_q[i].flags, '{expire: 0, rise: !i[0], fall: i[0], ovf: 0});
			if (i > 0)
				compare_bit("gap_ok", stamp_t'(rx_q[i].stamp - rx_q[i-1].stamp) == gaps[i], 1'b1);
		end
		@(posedge clk);
		cfg.rise_en <= 1'b0;
		repeat (5) @(posedge clk);
		i_sig <= 1'b1;
		repeat (5) @(posedge clk);
		i_sig <= 1'b0;
		wait_records(5, 50);
		repeat (10) @(negedge clk);
		compare_bit("no_rise_record", rx_q.size() == 5, 1'b1);
		compare_flags("flags", rx_q[4].flags, '{expire: 0, rise: 0, fall: 1, ovf: 0});
		go_idle();
		report("edges");
	endtask

	task automatic test_overflow();
		@(posedge clk);
		cfg <= '{div: 0, tmr_val: 0, tmr_en: 0, cap_en: 1, rise_en: 0, fall_en: 0};
		wait_records(2, 700);
		foreach (rx_q[i])
			compare_evt("o_evt", rx_q[i], '{flags: '{expire: 0, rise: 0, fall: 0, ovf: 1}, stamp: 0});
		if (rx_t.size() == 2)
			compare_bit("ovf_period_ok", rx_t[1] - rx_t[0] == 256, 1'b1);
		go_idle();
		report("overflow");
	endtask

	task automatic test_credits();
		int t;
		@(negedge clk);
		give_credit = 0;
		@(posedge clk);
		cfg <= '{div: 0, tmr_val: 3, tmr_en: 1, cap_en: 1, rise_en: 0, fall_en: 0};
		t = 0;
		while (!o_lost && t < 200) begin
			@(negedge clk);
			t++;
		end
		compare_bit("o_lost", o_lost, 1'b1);
		compare_bit("records_within_credits", rx_q.size() == `TCU_CREDITS, 1'b1);
		@(posedge clk);
		cfg <= '0;
		@(negedge clk);
		give_credit = 1;
		wait_records(`TCU_CREDITS + `TCU_EVQ_DEPTH, 100);
		repeat (20) @(negedge clk);
		compare_bit("no_extra_records", rx_q.size() == `TCU_CREDITS + `TCU_EVQ_DEPTH, 1'b1);
		foreach (rx_q[i])
			if (i > 0)
				compare_bit("stamp_step_ok", stamp_t'(rx_q[i].stamp - rx_q[i-1].stamp) == 4, 1'b1);
		go_idle();
		report("credits");
	endtask

	initial begin
		rst = 0;
		cfg = '0;
		i_sig = 0;
		i_evt_credit = 0;
		cyc = 0;
		owed = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		test_reset();
		test_timer();
		test_edges();
		test_overflow();
		test_credits();
		$display("%0d tests run, %0d errors", test_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tcu_asserts.sv */
// credit and queue assertions bound into the event merger
`timescale 1ns/1ps
`default_nettype none

`include "tcu_defs.svh"

module tcu_asserts (
	input wire                                 clk,
	input wire                                 rst,
	input wire                                 i_valid,
	input wire                                 i_evt_credit,
	input wire [$clog2(`TCU_CREDITS+1)-1:0]    i_credit_cnt,
	input wire                                 i_wr_en,
	input wire                                 i_rd_en
);
	import tcu_pkg::*;

	int model_credits;    // credits seen from the port handshake
	int model_fill;       // records written and not yet read

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			model_credits <= `TCU_CREDITS;
			model_fill    <= 0;
		end else begin
			model_credits <= model_credits - int'(i_valid) + int'(i_evt_credit);
			model_fill    <= model_fill + int'(i_wr_en) - int'(i_rd_en);
		end
	end

	valid_needs_credit: assert property (@(posedge clk) disable iff (!rst)
		i_valid |-> (model_credits > 0))
		else $error("record sent with no credit left");

	credit_ceiling: assert property (@(posedge clk) disable iff (!rst)
		i_credit_cnt <= `TCU_CREDITS)
		else $error("credit count above its ceiling");

	no_read_empty: assert property (@(posedge clk) disable iff (!rst)
		i_rd_en |-> (model_fill > 0))
		else $error("queue read while empty");

endmodule

`default_nettype wire

/* hdl/tcu_top.sv */
// timer and capture unit top level
`timescale 1ns/1ps
`default_nettype none

module tcu_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire tcu_pkg::tcu_cfg_t i_cfg,
	input  wire                    i_sig,
	input  wire                    i_evt_credit,
	output logic                   o_tmr_clk,
	output logic                   o_evt_valid,
	output tcu_pkg::evt_t          o_evt,
	output logic                   o_lost
);
	import tcu_pkg::*;

	logic       tick;
	logic       tmr_expire;
	logic       cap_rise;
	logic       cap_fall;
	logic       cap_ovf;
	stamp_t     cap_stamp;
	evt_flags_t evt_flags;

	assign evt_flags = '{expire: tmr_expire, rise: cap_rise, fall: cap_fall, ovf: cap_ovf};

	tick_prescaler tick_prescaler_inst (
		.clk    (clk),
		.rst    (rst),
		.i_div  (i_cfg.div),
		.o_tick (tick)
	);

	reload_timer reload_timer_inst (
		.clk       (clk),
		.rst       (rst),
		.i_tick    (tick),
		.i_en      (i_cfg.tmr_en),
		.i_reload  (i_cfg.tmr_val),
		.o_expire  (tmr_expire),
		.o_tmr_clk (o_tmr_clk)
	);

	edge_capture edge_capture_inst (
		.clk       (clk),
		.rst       (rst),
		.i_tick    (tick),
		.i_en      (i_cfg.cap_en),
		.i_rise_en (i_cfg.rise_en),
		.i_fall_en (i_cfg.fall_en),
		.i_sig     (i_sig),
		.o_rise    (cap_rise),
		.o_fall    (cap_fall),
		.o_ovf     (cap_ovf),
		.o_stamp   (cap_stamp)
	);

	event_merger event_merger_inst (
		.clk          (clk),
		.rst          (rst),
		.i_flags      (evt_flags),
		.i_stamp      (cap_stamp),
		.i_evt_credit (i_evt_credit),
		.o_evt_valid  (o_evt_valid),
		.o_evt        (o_evt),
		.o_lost       (o_lost)
	);

endmodule

`default_nettype wire

/* hdl/event_merger.sv */
// event merger with record builder, circular record queue and credit counter
`timescale 1ns/1ps
`default_nettype none

`include "tcu_defs.svh"

module event_merger (
	input  wire                      clk,
	input  wire                      rst,
	input  wire tcu_pkg::evt_flags_t i_flags,
	input  wire tcu_pkg::stamp_t     i_stamp,
	input  wire                      i_evt_credit,
	output logic                     o_evt_valid,
	output tcu_pkg::evt_t            o_evt,
	output logic                     o_lost
);
	import tcu_pkg::*;

	localparam int PTR_W  = $clog2(`TCU_EVQ_DEPTH) + 1;    // extra wrap bit
	localparam int CRED_W = $clog2(`TCU_CREDITS + 1);

	evt_t              evq_mem [`TCU_EVQ_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W-1:0]  fill;
	logic [CRED_W-1:0] credit_cnt;
	logic              any_evt;
	logic              empty;
	logic              full;
	logic              wr_en;
	logic              rd_en;

	assign any_evt = |i_flags;
	assign fill    = wr_ptr - rd_ptr;
	assign empty   = (fill == '0);
	assign full    = (fill == PTR_W'(`TCU_EVQ_DEPTH));

	assign wr_en = any_evt & ~full;
	assign rd_en = ~empty & (credit_cnt != '0);    // one record per credit

	assign o_evt_valid = rd_en;
	assign o_evt       = evq_mem[rd_ptr[PTR_W-2:0]];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			evq_mem[wr_ptr[PTR_W-2:0]] <= '{flags: i_flags, stamp: i_stamp};
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			credit_cnt <= CRED_W'(`TCU_CREDITS);
		end else begin
			case ({rd_en, i_evt_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;    // send and return cancel
			endcase
		end
	end

	// sticky until reset
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_lost <= 1'b0;
		end else if (any_evt & full) begin
			o_lost <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/edge_capture.sv */
// edge capture with input synchronizer, edge detect and stamp counter with overflow
`timescale 1ns/1ps
`default_nettype none

module edge_capture (
	input  wire             clk,
	input  wire             rst,
	input  wire             i_tick,
	input  wire             i_en,
	input  wire             i_rise_en,
	input  wire             i_fall_en,
	input  wire             i_sig,
	output logic            o_rise,
	output logic            o_fall,
	output logic            o_ovf,
	output tcu_pkg::stamp_t o_stamp
);
	import tcu_pkg::*;

	logic [2:0] sync_q;    // sync_q[0] samples the raw input
	stamp_t     stamp_cnt;
	stamp_t     stamp_inc;
	logic       stamp_carry;
	logic       stamp_step;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[1:0], i_sig};
		end
	end

	assign o_rise = i_en & i_rise_en & (sync_q[2:1] == 2'b01);
	assign o_fall = i_en & i_fall_en & (sync_q[2:1] == 2'b10);

	assign stamp_step = i_en & i_tick;
	assign {stamp_carry, stamp_inc} = {1'b0, stamp_cnt} + 1'b1;

	// carry out of the counter marks the wrap
	assign o_ovf = stamp_step & stamp_carry;

	// stamp seen by this cycle's events includes its tick
	assign o_stamp = stamp_step ? stamp_inc : stamp_cnt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stamp_cnt <= '0;
		end else if (!i_en) begin
			stamp_cnt <= '0;
		end else if (i_tick) begin
			stamp_cnt <= stamp_inc;
		end
	end

endmodule

`default_nettype wire

/* hdl/reload_timer.sv */
// reload timer with square wave toggle output and expiry pulse
`timescale 1ns/1ps
`default_nettype none

module reload_timer (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    i_tick,
	input  wire                    i_en,
	input  wire tcu_pkg::tmr_val_t i_reload,
	output logic                   o_expire,
	output logic                   o_tmr_clk
);
	import tcu_pkg::*;

	tmr_val_t tmr_cnt;
	logic     armed;      // set by the first load
	logic     tmr_tgl;
	logic     at_zero;

	assign at_zero   = (tmr_cnt == '0);
	assign o_expire  = i_en & i_tick & at_zero & armed;    // same cycle as the tick
	assign o_tmr_clk = tmr_tgl;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tmr_cnt <= '0;
			armed   <= 1'b0;
			tmr_tgl <= 1'b0;
		end else if (!i_en) begin
			tmr_cnt <= '0;
			armed   <= 1'b0;
			tmr_tgl <= 1'b0;
		end else if (i_tick) begin
			if (at_zero) begin
				tmr_cnt <= i_reload;
				armed   <= 1'b1;
				tmr_tgl <= tmr_tgl ^ armed;    // first load only arms
			end else begin
				tmr_cnt <= tmr_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/tick_prescaler.sv */
// tick prescaler, one clock wide tick every i_div+1 cycles
`timescale 1ns/1ps
`default_nettype none

`include "tcu_defs.svh"

module tick_prescaler (
	input  wire                  clk,
	input  wire                  rst,
	input  wire [`TCU_DIV_W-1:0] i_div,
	output logic                 o_tick
);

	logic [`TCU_DIV_W-1:0] div_cnt;

	// >= so a lowered divider does not wait for a wrap
	assign o_tick = (div_cnt >= i_div);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div_cnt <= '0;
		end else if (o_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/tcu_pkg.sv */
// tcu package with configuration, stamp, event flag and event record types
`default_nettype none

`include "tcu_defs.svh"

package tcu_pkg;

	typedef logic [`TCU_TMR_W-1:0] tmr_val_t;
	typedef logic [`TCU_STAMP_W-1:0] stamp_t;

	typedef struct packed {
		logic [`TCU_DIV_W-1:0] div;    // tick every div+1 clocks
		tmr_val_t              tmr_val;
		logic                  tmr_en;
		logic                  cap_en;
		logic                  rise_en;
		logic                  fall_en;
	} tcu_cfg_t;

	typedef struct packed {
		logic expire;
		logic rise;
		logic fall;
		logic ovf;
	} evt_flags_t;

	typedef struct packed {
		evt_flags_t flags;
		stamp_t     stamp;    // counter value after this cycle's tick
	} evt_t;

endpackage

`default_nettype wire

/* hdl/tcu_defs.svh */
// tcu width, queue depth and credit macros
`ifndef TCU_DEFS_SVH
`define TCU_DEFS_SVH

// prescaler divide setting
`define TCU_DIV_W 8
// timer reload value
`define TCU_TMR_W 16
// capture stamp counter
`define TCU_STAMP_W 8
// records held by the event queue
`define TCU_EVQ_DEPTH 8
// credits after reset, also the ceiling
`define TCU_CREDITS 4

`endif
